//--- Makefile
TOOL  = verilator
FLAGS = --binary --assert --timing -j 0
TOP   = tb_mycpu
FLIST = flist.f

SRCS = $(shell grep -v '^+' $(FLIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx 'All checks passed'

clean:
	rm -rf obj_dir

//--- flist.f
rtl/mips_pkg.sv
rtl/mem_handshake.sv
rtl/instr_decode.sv
rtl/alu_execute.sv
rtl/reg_file.sv
rtl/writeback_select.sv
rtl/core_control.sv
rtl/mycpu.sv
verif/sram_model.sv
verif/tb_mycpu.sv

//--- rtl/alu_execute.sv
`timescale 1ns/1ps

module alu_execute (
    input  mips_pkg::decoded_t     dec,
    input  mips_pkg::word_t        pc,
    input  mips_pkg::word_t        rs_data,
    input  mips_pkg::word_t        rt_data,
    output mips_pkg::exec_result_t result
);

    mips_pkg::word_t operand_b;
    mips_pkg::word_t pc_plus4;
    mips_pkg::word_t branch_target;
    logic            rs_eq_rt;
    logic            take_branch;

    assign operand_b = dec.use_imm ? dec.imm : rt_data;

    // effective address for lw/sw falls out of alu_add
    always_comb begin
        case (dec.alu_op)
            mips_pkg::alu_add: result.alu_out = rs_data + operand_b;
            mips_pkg::alu_sub: result.alu_out = rs_data - operand_b;
            mips_pkg::alu_and: result.alu_out = rs_data & operand_b;
            mips_pkg::alu_or:  result.alu_out = rs_data | operand_b;
            mips_pkg::alu_slt: begin
                result.alu_out = {31'b0, $signed(rs_data) < $signed(operand_b)};
            end
            mips_pkg::alu_sll: result.alu_out = rt_data << dec.shamt;
            mips_pkg::alu_lui: result.alu_out = {operand_b[15:0], 16'h0000};
            default:           result.alu_out = '0;
        endcase
    end

    assign result.store_data = rt_data;

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {dec.imm[29:0], 2'b00};
    assign rs_eq_rt      = (rs_data == rt_data);
    assign take_branch   = dec.is_branch && (rs_eq_rt ^ dec.branch_ne);

    // no delay slot, the target follows directly
    always_comb begin
        if (dec.is_jump) begin
            result.next_pc = {pc_plus4[31:28], dec.jump_index, 2'b00};
        end else if (take_branch) begin
            result.next_pc = branch_target;
        end else begin
            result.next_pc = pc_plus4;
        end
    end

endmodule

//--- rtl/core_control.sv
`timescale 1ns/1ps

module core_control #(
    parameter mips_pkg::word_t reset_pc = 32'hbfc0_0000
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   i_data_ok,
    input  logic                   d_data_ok,
    input  mips_pkg::word_t        inst_rdata,
    input  mips_pkg::word_t        data_rdata,
    input  mips_pkg::exec_result_t result,
    input  mips_pkg::decoded_t     dec,
    output logic                   inst_cpu_req,
    output mips_pkg::word_t        pc,
    output mips_pkg::word_t        instr,
    output logic                   data_cpu_req,
    output logic                   data_wr,
    output mips_pkg::word_t        data_vaddr,
    output mips_pkg::word_t        data_wdata,
    output mips_pkg::word_t        load_data,
    output logic                   commit
);

    mips_pkg::core_state_t  state;
    mips_pkg::exec_result_t exec_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mips_pkg::fetch_req;
            pc    <= reset_pc;
        end else begin
            case (state)
                mips_pkg::fetch_req:  state <= mips_pkg::fetch_wait;
                mips_pkg::fetch_wait: begin
                    if (i_data_ok) begin
                        state <= mips_pkg::decode;
                    end
                end
                mips_pkg::decode:     state <= mips_pkg::execute;
                mips_pkg::execute: begin
                    if (dec.mem_read || dec.mem_write) begin
                        state <= mips_pkg::mem_req;
                    end else begin
                        state <= mips_pkg::writeback;
                    end
                end
                mips_pkg::mem_req:    state <= mips_pkg::mem_wait;
                mips_pkg::mem_wait: begin
                    if (d_data_ok) begin
                        state <= mips_pkg::writeback;
                    end
                end
                mips_pkg::writeback: begin
                    pc    <= exec_q.next_pc;
                    state <= mips_pkg::fetch_req;
                end
                default: state <= mips_pkg::fetch_req;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (state == mips_pkg::fetch_wait && i_data_ok) begin
            instr <= inst_rdata;
        end
        if (state == mips_pkg::execute) begin
            exec_q <= result;
        end
        if (state == mips_pkg::mem_wait && d_data_ok) begin
            load_data <= data_rdata;
        end
    end

    // request level held over both req and wait states
    assign inst_cpu_req = (state == mips_pkg::fetch_req) || (state == mips_pkg::fetch_wait);
    assign data_cpu_req = (state == mips_pkg::mem_req) || (state == mips_pkg::mem_wait);
    assign data_wr      = dec.mem_write;
    assign data_vaddr   = exec_q.alu_out;
    assign data_wdata   = exec_q.store_data;
    assign commit       = (state == mips_pkg::writeback);

endmodule

//--- rtl/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
    input  mips_pkg::word_t    instr,
    output mips_pkg::decoded_t dec
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign imm16  = instr[15:0];

    always_comb begin
        dec            = '0;
        dec.alu_op     = mips_pkg::alu_add;
        dec.rs         = instr[25:21];
        dec.rt         = instr[20:16];
        // immediate forms write rt
        dec.dest       = instr[20:16];
        dec.shamt      = instr[10:6];
        dec.jump_index = instr[25:0];

        case (opcode)
            mips_pkg::op_special: begin
                dec.dest      = instr[15:11];
                dec.reg_write = 1'b1;
                case (funct)
                    6'h21: dec.alu_op = mips_pkg::alu_add;
                    6'h23: dec.alu_op = mips_pkg::alu_sub;
                    6'h24: dec.alu_op = mips_pkg::alu_and;
                    6'h25: dec.alu_op = mips_pkg::alu_or;
                    6'h2a: dec.alu_op = mips_pkg::alu_slt;
                    6'h00: dec.alu_op = mips_pkg::alu_sll;
                    // unknown funct becomes a no-op
                    default: dec.reg_write = 1'b0;
                endcase
            end
            mips_pkg::op_addiu: begin
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            mips_pkg::op_ori: begin
                dec.alu_op    = mips_pkg::alu_or;
                dec.use_imm   = 1'b1;
                dec.zero_ext  = 1'b1;
                dec.reg_write = 1'b1;
            end
            mips_pkg::op_lui: begin
                dec.alu_op    = mips_pkg::alu_lui;
                dec.use_imm   = 1'b1;
                dec.zero_ext  = 1'b1;
                dec.reg_write = 1'b1;
            end
            mips_pkg::op_lw: begin
                dec.use_imm   = 1'b1;
                dec.mem_read  = 1'b1;
                dec.reg_write = 1'b1;
            end
            mips_pkg::op_sw: begin
                dec.use_imm   = 1'b1;
                dec.mem_write = 1'b1;
            end
            mips_pkg::op_beq: dec.is_branch = 1'b1;
            mips_pkg::op_bne: begin
                dec.is_branch = 1'b1;
                dec.branch_ne = 1'b1;
            end
            mips_pkg::op_j: dec.is_jump = 1'b1;
            default: dec.reg_write = 1'b0;
        endcase

        dec.imm = dec.zero_ext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
    end

endmodule

//--- rtl/mem_handshake.sv
`timescale 1ns/1ps

module mem_handshake (
    input  logic clk,
    input  logic reset,
    input  logic cpu_req,
    input  logic addr_ok,
    input  logic data_ok,
    output logic req,
    output logic cpu_data_ok
);

    typedef enum logic {
        hs_idle,
        hs_waiting
    } hs_state_t;

    hs_state_t state;

    // request goes out only while nothing is outstanding
    assign req         = (state == hs_idle) && cpu_req;
    assign cpu_data_ok = (state == hs_waiting) && data_ok;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= hs_idle;
        end else begin
            case (state)
                hs_idle: begin
                    // address accepted this cycle
                    if (cpu_req && addr_ok) begin
                        state <= hs_waiting;
                    end
                end
                hs_waiting: begin
                    if (data_ok) begin
                        state <= hs_idle;
                    end
                end
                default: state <= hs_idle;
            endcase
        end
    end

endmodule

//--- rtl/mips_pkg.sv
package mips_pkg;

    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  creg_addr_t;
    typedef logic [3:0]  rwen_t;

    // primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_sll,
        alu_lui
    } alu_op_t;

    // one instruction at a time, no overlap between states
    typedef enum logic [2:0] {
        fetch_req,
        fetch_wait,
        decode,
        execute,
        mem_req,
        mem_wait,
        writeback
    } core_state_t;

    typedef struct packed {
        alu_op_t    alu_op;
        logic       use_imm;
        logic       zero_ext;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       is_branch;
        logic       branch_ne;
        logic       is_jump;
        creg_addr_t rs;
        creg_addr_t rt;
        creg_addr_t dest;
        word_t      imm;
        logic [4:0] shamt;
        logic [25:0] jump_index;
    } decoded_t;

    typedef struct packed {
        word_t alu_out;
        word_t store_data;
        word_t next_pc;
    } exec_result_t;

endpackage

//--- rtl/mycpu.sv
`timescale 1ns/1ps

module mycpu #(
    parameter logic            do_addr_translation = 1'b1,
    parameter mips_pkg::word_t reset_pc            = 32'hbfc0_0000
) (
    input  logic                 clk,
    input  logic                 reset,

    output logic                 inst_req,
    output logic                 inst_wr,
    output logic [1:0]           inst_size,
    output mips_pkg::word_t      inst_addr,
    output mips_pkg::word_t      inst_wdata,
    output logic                 data_req,
    output logic                 data_wr,
    output logic [1:0]           data_size,
    output mips_pkg::word_t      data_addr,
    output mips_pkg::word_t      data_wdata,
    input  mips_pkg::word_t      inst_rdata,
    input  mips_pkg::word_t      data_rdata,
    input  logic                 inst_addr_ok,
    input  logic                 data_addr_ok,
    input  logic                 inst_data_ok,
    input  logic                 data_data_ok,

    output mips_pkg::word_t      debug_wb_pc,
    output mips_pkg::rwen_t      debug_wb_rf_wen,
    output mips_pkg::creg_addr_t debug_wb_rf_wnum,
    output mips_pkg::word_t      debug_wb_rf_wdata
);

    mips_pkg::decoded_t     dec;
    mips_pkg::exec_result_t result;
    mips_pkg::word_t        pc;
    mips_pkg::word_t        instr;
    mips_pkg::word_t        data_vaddr;
    mips_pkg::word_t        load_data;
    mips_pkg::word_t        rs_data;
    mips_pkg::word_t        rt_data;
    mips_pkg::word_t        rf_wdata;
    mips_pkg::creg_addr_t   rf_waddr;
    logic                   rf_wen;
    logic                   inst_cpu_req;
    logic                   data_cpu_req;
    logic                   i_data_ok;
    logic                   d_data_ok;
    logic                   commit;

    // kseg0/kseg1 map onto the low 512 MB
    function automatic mips_pkg::word_t to_phys(input mips_pkg::word_t va);
        if (do_addr_translation && (va[31:30] == 2'b10)) begin
            return {3'b000, va[28:0]};
        end
        return va;
    endfunction

    assign inst_wr    = 1'b0;
    assign inst_size  = 2'b10;
    assign inst_wdata = '0;
    assign inst_addr  = to_phys(pc);
    assign data_size  = 2'b10;
    assign data_addr  = to_phys(data_vaddr);

    core_control #(
        .reset_pc(reset_pc)
    ) core_control_inst (
        .clk, .reset, .i_data_ok, .d_data_ok, .inst_rdata, .data_rdata,
        .result, .dec, .inst_cpu_req, .pc, .instr, .data_cpu_req, .data_wr,
        .data_vaddr, .data_wdata, .load_data, .commit
    );

    instr_decode instr_decode_inst (.instr, .dec);

    reg_file reg_file_inst (
        .clk, .raddr1(dec.rs), .raddr2(dec.rt), .rdata1(rs_data), .rdata2(rt_data),
        .wen(rf_wen), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    alu_execute alu_execute_inst (.dec, .pc, .rs_data, .rt_data, .result);

    writeback_select writeback_select_inst (
        .clk, .reset, .commit, .dec, .pc, .alu_out(data_vaddr), .load_data,
        .rf_wen, .rf_waddr, .rf_wdata, .debug_wb_pc, .debug_wb_rf_wen,
        .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    mem_handshake i_handshake (
        .clk, .reset, .cpu_req(inst_cpu_req), .addr_ok(inst_addr_ok),
        .data_ok(inst_data_ok), .req(inst_req), .cpu_data_ok(i_data_ok)
    );

    mem_handshake d_handshake (
        .clk, .reset, .cpu_req(data_cpu_req), .addr_ok(data_addr_ok),
        .data_ok(data_data_ok), .req(data_req), .cpu_data_ok(d_data_ok)
    );

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                 clk,
    input  mips_pkg::creg_addr_t raddr1,
    input  mips_pkg::creg_addr_t raddr2,
    output mips_pkg::word_t      rdata1,
    output mips_pkg::word_t      rdata2,
    input  logic                 wen,
    input  mips_pkg::creg_addr_t waddr,
    input  mips_pkg::word_t      wdata
);

    mips_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // $0 is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- rtl/writeback_select.sv
`timescale 1ns/1ps

module writeback_select (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 commit,
    input  mips_pkg::decoded_t   dec,
    input  mips_pkg::word_t      pc,
    input  mips_pkg::word_t      alu_out,
    input  mips_pkg::word_t      load_data,
    output logic                 rf_wen,
    output mips_pkg::creg_addr_t rf_waddr,
    output mips_pkg::word_t      rf_wdata,
    output mips_pkg::word_t      debug_wb_pc,
    output mips_pkg::rwen_t      debug_wb_rf_wen,
    output mips_pkg::creg_addr_t debug_wb_rf_wnum,
    output mips_pkg::word_t      debug_wb_rf_wdata
);

    mips_pkg::word_t      wb_value;
    logic                 do_write;
    mips_pkg::word_t      last_pc;
    mips_pkg::creg_addr_t last_wnum;
    mips_pkg::word_t      last_wdata;

    assign wb_value = dec.mem_read ? load_data : alu_out;
    assign do_write = commit && dec.reg_write && (dec.dest != '0);

    assign rf_wen   = do_write;
    assign rf_waddr = dec.dest;
    assign rf_wdata = wb_value;

    // trace keeps the last committed values between instructions
    always_ff @(posedge clk) begin
        if (reset) begin
            last_pc    <= '0;
            last_wnum  <= '0;
            last_wdata <= '0;
        end else if (commit) begin
            last_pc    <= pc;
            last_wnum  <= dec.dest;
            last_wdata <= wb_value;
        end
    end

    assign debug_wb_pc       = commit ? pc : last_pc;
    assign debug_wb_rf_wen   = {4{do_write}};
    assign debug_wb_rf_wnum  = commit ? dec.dest : last_wnum;
    assign debug_wb_rf_wdata = commit ? wb_value : last_wdata;

endmodule

//--- verif/sram_model.sv
`timescale 1ns/1ps

module sram_model (
    input  logic            clk,
    input  logic            reset,
    input  logic            inst_req,
    input  logic            inst_wr,
    input  mips_pkg::word_t inst_addr,
    input  mips_pkg::word_t inst_wdata,
    output logic            inst_addr_ok,
    output logic            inst_data_ok,
    output mips_pkg::word_t inst_rdata,
    input  logic            data_req,
    input  logic            data_wr,
    input  mips_pkg::word_t data_addr,
    input  mips_pkg::word_t data_wdata,
    output logic            data_addr_ok,
    output logic            data_data_ok,
    output mips_pkg::word_t data_rdata
);

    mips_pkg::word_t mem [256];
    // port 0 is instruction, port 1 is data
    logic            req [2];
    logic            wr [2];
    mips_pkg::word_t addr [2];
    mips_pkg::word_t wdata [2];
    logic            acc [2];
    logic            done [2];
    logic            addr_ok [2];
    logic            data_ok [2];
    mips_pkg::word_t rdata [2];
    logic            cap_wr [2];
    mips_pkg::word_t cap_addr [2];
    mips_pkg::word_t cap_wdata [2];
    logic            phase [2];
    int unsigned     cnt [2];
    logic            reset_q = 1'b1;
    logic [31:0]     lcg_state = 32'h4803_ff2b;

    assign req[0]   = inst_req;
    assign wr[0]    = inst_wr;
    assign addr[0]  = inst_addr;
    assign wdata[0] = inst_wdata;
    assign req[1]   = data_req;
    assign wr[1]    = data_wr;
    assign addr[1]  = data_addr;
    assign wdata[1] = data_wdata;

    assign inst_addr_ok = addr_ok[0];
    assign inst_data_ok = data_ok[0];
    assign inst_rdata   = rdata[0];
    assign data_addr_ok = addr_ok[1];
    assign data_data_ok = data_ok[1];
    assign data_rdata   = rdata[1];

    // delay of 0 to 3 cycles from an LCG
    function automatic int unsigned next_delay();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {30'b0, lcg_state[17:16]};
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'ha5a5_a5a5 ^ (32'h1fc0_0000 + 32'(i) * 32'd4);
        end
        for (int p = 0; p < 2; p++) begin
            addr_ok[p] = 1'b0;
            data_ok[p] = 1'b0;
            rdata[p]   = '0;
            phase[p]   = 1'b0;
            cnt[p]     = 0;
        end
    end

    // handshake and reset seen at the edge, sampled while stable
    always @(negedge clk) begin
        reset_q = reset;
        for (int p = 0; p < 2; p++) begin
            acc[p]  = req[p] && addr_ok[p];
            done[p] = data_ok[p];
            if (acc[p]) begin
                cap_wr[p]    = wr[p];
                cap_addr[p]  = addr[p];
                cap_wdata[p] = wdata[p];
            end
        end
    end

    always @(posedge clk) begin
        #1;
        for (int p = 0; p < 2; p++) begin
            addr_ok[p] = 1'b0;
            data_ok[p] = 1'b0;
            if (reset_q) begin
                phase[p] = 1'b0;
                cnt[p]   = 0;
            end else if (!phase[p]) begin
                if (acc[p]) begin
                    rdata[p] = mem[cap_addr[p][9:2]];
                    if (cap_wr[p]) begin
                        mem[cap_addr[p][9:2]] = cap_wdata[p];
                    end
                    phase[p] = 1'b1;
                    cnt[p]   = next_delay();
                end else if (req[p]) begin
                    if (cnt[p] == 0) begin
                        addr_ok[p] = 1'b1;
                    end else begin
                        cnt[p] = cnt[p] - 1;
                    end
                end
            end else if (done[p]) begin
                phase[p] = 1'b0;
                cnt[p]   = next_delay();
            end else if (cnt[p] == 0) begin
                data_ok[p] = 1'b1;
            end else begin
                cnt[p] = cnt[p] - 1;
            end
        end
    end

endmodule

//--- verif/tb_mycpu.sv
`timescale 1ns/1ps

module tb_mycpu;

    localparam int PROG_LEN = 23;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic inst_req, inst_wr, inst_addr_ok, inst_data_ok;
    logic data_req, data_wr, data_addr_ok, data_data_ok;
    logic [1:0] inst_size, data_size;
    mips_pkg::word_t inst_addr, inst_wdata, inst_rdata;
    mips_pkg::word_t data_addr, data_wdata, data_rdata;
    mips_pkg::word_t debug_wb_pc, debug_wb_rf_wdata;
    mips_pkg::rwen_t debug_wb_rf_wen;
    mips_pkg::creg_addr_t debug_wb_rf_wnum;

    // lui/ori base, alu ops, $0 write, sw/lw, branches, j, j-self
    mips_pkg::word_t prog [PROG_LEN] = '{
        32'h3c01bfc0, 32'h34210100, 32'h2402fffb, 32'h24030007, 32'h00432021,
        32'h00432823, 32'h00833024, 32'h00433825, 32'h0043402a, 32'h00034900,
        32'h24000055, 32'h00035021, 32'hac250000, 32'h8c2b0000, 32'h11650001,
        32'h240c0001, 32'h14840001, 32'h240d0002, 32'h14430001, 32'h240e0003,
        32'h0bf00016, 32'h240f0004, 32'h0bf00016
    };

    mips_pkg::word_t sregs [32];
    mips_pkg::word_t smem [mips_pkg::word_t];
    mips_pkg::word_t spc = 32'hbfc0_0000;
    int fails [7];
    int loop_commits = 0;
    int commits = 0;
    logic seen_fetch = 1'b0;
    logic post_reset_checked = 1'b0;
    logic i_out = 1'b0;
    logic d_out = 1'b0;
    logic finished = 1'b0;

    mycpu mycpu_inst (.*);

    sram_model sram_inst (.*);

    always #5 clk = ~clk;

    task automatic report_mismatch(input int test, input string name,
                                   input mips_pkg::word_t exp, input mips_pkg::word_t act);
        $display("** Error: test %0d %s expected %h actual %h at %0t", test, name, exp, act,
                 $time);
        fails[test]++;
    endtask

    task automatic note_failure(input int test, input string msg);
        $display("test %0d failure: %s at %0t", test, msg, $time);
        fails[test]++;
    endtask

    function automatic mips_pkg::word_t prog_word_at(input mips_pkg::word_t va);
        mips_pkg::word_t offs;
        offs = (va - 32'hbfc0_0000) >> 2;
        return prog[offs[4:0]];
    endfunction

    // req held with a stable address until addr_ok
    assert property (@(posedge clk) disable iff (reset)
        inst_req && !inst_addr_ok |=> inst_req && $stable(inst_addr))
        else note_failure(5, "inst_req dropped or inst_addr moved before addr_ok");
    assert property (@(posedge clk) disable iff (reset)
        data_req && !data_addr_ok |=> data_req && $stable(data_addr) && $stable(data_wr))
        else note_failure(5, "data_req dropped or data address moved before addr_ok");

    always @(negedge clk) begin
        mips_pkg::word_t cur;
        if (!reset) begin
            // first cycle out of reset
            if (!post_reset_checked) begin
                post_reset_checked = 1'b1;
                assert (inst_req) else report_mismatch(1, "inst_req", 32'h1, 32'h0);
                assert (!data_req) else report_mismatch(1, "data_req", 32'h0, 32'h1);
                assert (debug_wb_rf_wen == 4'h0)
                    else report_mismatch(1, "debug_wb_rf_wen", 32'h0,
                                         {28'b0, debug_wb_rf_wen});
            end
            if (!seen_fetch && inst_req && inst_addr_ok) begin
                seen_fetch = 1'b1;
                assert (inst_addr == 32'h1fc0_0000)
                    else report_mismatch(1, "inst_addr", 32'h1fc0_0000, inst_addr);
            end
            if (inst_req) begin
                assert (!inst_wr) else report_mismatch(5, "inst_wr", 32'h0, 32'h1);
                assert (inst_size == 2'b10)
                    else report_mismatch(5, "inst_size", 32'h2, {30'b0, inst_size});
                assert (inst_wdata == '0)
                    else report_mismatch(5, "inst_wdata", 32'h0, inst_wdata);
            end
            // every data access in the program uses kseg1 0xbfc00100
            if (data_req && data_addr_ok) begin
                cur = prog_word_at(spc);
                assert (data_size == 2'b10)
                    else report_mismatch(5, "data_size", 32'h2, {30'b0, data_size});
                assert (data_addr == 32'h1fc0_0100)
                    else report_mismatch(4, "data_addr", 32'h1fc0_0100, data_addr);
                assert (data_wr == (cur[31:26] == 6'h2b))
                    else report_mismatch(4, "data_wr", {31'b0, cur[31:26] == 6'h2b},
                                         {31'b0, data_wr});
                if (data_wr) begin
                    assert (data_wdata == sregs[cur[20:16]])
                        else report_mismatch(4, "data_wdata", sregs[cur[20:16]], data_wdata);
                end
            end
            assert (!(i_out && inst_req))
                else note_failure(5, "second inst_req before inst_data_ok");
            assert (!(d_out && data_req))
                else note_failure(5, "second data_req before data_data_ok");
            if (inst_data_ok) i_out = 1'b0;
            if (inst_req && inst_addr_ok) i_out = 1'b1;
            if (data_data_ok) d_out = 1'b0;
            if (data_req && data_addr_ok) d_out = 1'b1;
        end
    end

    // shadow model, one instruction per writeback cycle
    always @(negedge clk) begin
        mips_pkg::word_t ins, a, b, simm, val, npc, offs;
        logic [4:0] dest;
        logic wen;
        if (!reset && mycpu_inst.commit) begin
            offs = (spc - 32'hbfc0_0000) >> 2;
            ins  = prog[offs[4:0]];
            a    = sregs[ins[25:21]];
            b    = sregs[ins[20:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            npc  = spc + 32'd4;
            dest = ins[20:16];
            wen  = 1'b1;
            val  = '0;
            case (ins[31:26])
                6'h00: begin
                    dest = ins[15:11];
                    case (ins[5:0])
                        6'h21: val = a + b;
                        6'h23: val = a - b;
                        6'h24: val = a & b;
                        6'h25: val = a | b;
                        6'h2a: val = {31'b0, $signed(a) < $signed(b)};
                        default: val = b << ins[10:6];
                    endcase
                end
                6'h09: val = a + simm;
                6'h0d: val = a | {16'h0000, ins[15:0]};
                6'h0f: val = {ins[15:0], 16'h0000};
                6'h23: val = smem[a + simm];
                6'h2b: begin
                    smem[a + simm] = b;
                    wen = 1'b0;
                end
                6'h04, 6'h05: begin
                    wen = 1'b0;
                    if ((a == b) != ins[26]) npc = spc + 32'd4 + {simm[29:0], 2'b00};
                end
                default: begin
                    wen = 1'b0;
                    npc = {npc[31:28], ins[25:0], 2'b00};
                end
            endcase
            wen = wen && (dest != 5'd0);
            assert (debug_wb_pc == spc) else report_mismatch(6, "debug_wb_pc", spc, debug_wb_pc);
            assert (debug_wb_rf_wen == {4{wen}})
                else report_mismatch(3, "debug_wb_rf_wen", {28'b0, {4{wen}}},
                                     {28'b0, debug_wb_rf_wen});
            if (wen) begin
                assert (debug_wb_rf_wnum == dest)
                    else report_mismatch(2, "debug_wb_rf_wnum", {27'b0, dest},
                                         {27'b0, debug_wb_rf_wnum});
                assert (debug_wb_rf_wdata == val)
                    else report_mismatch((ins[31:26] == 6'h23) ? 4 : 2, "debug_wb_rf_wdata",
                                         val, debug_wb_rf_wdata);
                sregs[dest] = val;
            end
            if (npc == spc) loop_commits++;
            commits++;
            spc = npc;
            if (loop_commits == 2) finished = 1'b1;
        end
    end

    // about 20 cycles per instruction covers the worst bus delays
    initial begin
        repeat (PROG_LEN * 20 + 10) @(posedge clk);
        $display("watchdog expired after %0d commits, final loop not reached", commits);
        $display("Checks failed");
        $finish;
    end

    initial begin
        int failed_tests;
        int total;
        failed_tests = 0;
        total = 0;
        for (int r = 0; r < 32; r++) sregs[r] = '0;
        #1;
        for (int i = 0; i < PROG_LEN; i++) sram_inst.mem[i] = prog[i];
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
        wait (finished);
        @(posedge clk);
        for (int t = 1; t <= 6; t++) begin
            $display("test %0d: %s (%0d errors)", t, (fails[t] == 0) ? "PASS" : "FAIL",
                     fails[t]);
            if (fails[t] != 0) failed_tests++;
            total += fails[t];
        end
        $display("%0d tests passed, %0d tests failed, %0d commits", 6 - failed_tests,
                 failed_tests, commits);
        if (total == 0 && seen_fetch) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
